// File: vlog.f
source/cache_pkg.sv
source/bus_pkg.sv
source/cache_line.sv
source/line_refill_ctrl.sv
source/dual_port_cache.sv
verification/burst_mem_model.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cache_tb -f vlog.f \
  && ./obj_dir/Vcache_tb | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// File: verification/cache_tb.sv
// testbench that applies a stimulus table to the dual-port cache and checks it against a shadow memory
`timescale 1ns/1ps
module cache_tb import cache_pkg::*, bus_pkg::*; ();

  localparam int    LINE_WORDS = 4;
  localparam int    INDEX_BITS = 2;
  localparam int    NUM_ROWS   = 20;
  localparam int    TIMEOUT    = 200;
  localparam word_t FILL_MASK  = 32'h5A5A_0000;

  typedef enum logic [1:0] {A_NONE, A_READ, A_WRITE} a_op_e;

  typedef struct packed {
    a_op_e    a_op;
    addr_t    a_addr;
    word_t    a_data;
    byte_en_t a_be;
    logic     b_read;
    addr_t    b_addr;
    logic     hit;      // active ports finish with zero wait
  } row_t;

  logic     clk;
  logic     rst_n;
  cpu_req_t a_req;
  rd_req_t  b_req;
  word_t    a_readdata;
  word_t    b_readdata;
  logic     a_wait;
  logic     b_wait;
  mem_req_t mem_req;
  word_t    mem_readdata;
  logic     mem_wait;
  logic     mem_rvalid;

  row_t  rows [NUM_ROWS];
  word_t shadow [addr_t];
  int    data_errs;
  int    ctrl_errs;
  int    timeouts;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  dual_port_cache #(
    .LINE_WORDS (LINE_WORDS),
    .INDEX_BITS (INDEX_BITS)
  ) u_dual_port_cache (
    .clk                 (clk),
    .rst_n               (rst_n),
    .a_req_i             (a_req),
    .a_readdata_o        (a_readdata),
    .a_waitrequest_o     (a_wait),
    .b_req_i             (b_req),
    .b_readdata_o        (b_readdata),
    .b_waitrequest_o     (b_wait),
    .mem_req_o           (mem_req),
    .mem_readdata_i      (mem_readdata),
    .mem_waitrequest_i   (mem_wait),
    .mem_readdatavalid_i (mem_rvalid)
  );

  burst_mem_model #(
    .LINE_WORDS (LINE_WORDS)
  ) u_mem (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (mem_req),
    .readdata_o      (mem_readdata),
    .waitrequest_o   (mem_wait),
    .readdatavalid_o (mem_rvalid)
  );

  function automatic word_t shadow_read(addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return a ^ FILL_MASK;
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
    word_t res;
    res = old_w;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      ctrl_errs++;
      $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // index is addr[5:4] and tag starts at bit 6
  task automatic load_rows();
    rows[0]  = '{A_READ,  32'h0000_0100, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b0};
    rows[1]  = '{A_READ,  32'h0000_010C, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b1};
    rows[2]  = '{A_WRITE, 32'h0000_0104, 32'hDEAD_BEEF, 4'h5, 1'b0, 32'h0000_0000, 1'b1};
    rows[3]  = '{A_READ,  32'h0000_0104, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b1};
    rows[4]  = '{A_WRITE, 32'h0000_0108, 32'h1234_5678, 4'hF, 1'b0, 32'h0000_0000, 1'b1};
    rows[5]  = '{A_READ,  32'h0000_0140, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b0};
    rows[6]  = '{A_READ,  32'h0000_0104, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b0};
    rows[7]  = '{A_READ,  32'h0000_0108, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b1};
    rows[8]  = '{A_NONE,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0210, 1'b0};
    rows[9]  = '{A_NONE,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0100, 1'b1};
    rows[10] = '{A_WRITE, 32'h0000_0228, 32'hABCD_1234, 4'hC, 1'b0, 32'h0000_0000, 1'b0};
    rows[11] = '{A_NONE,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0228, 1'b1};
    rows[12] = '{A_READ,  32'h0000_0330, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0250, 1'b0};
    rows[13] = '{A_WRITE, 32'h0000_0334, 32'hCAFE_F00D, 4'h3, 1'b0, 32'h0000_0000, 1'b1};
    rows[14] = '{A_READ,  32'h0000_0270, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0118, 1'b0};
    rows[15] = '{A_READ,  32'h0000_0334, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b0};
    rows[16] = '{A_NONE,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0228, 1'b1};
    rows[17] = '{A_READ,  32'h0000_022C, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0228, 1'b1};
    rows[18] = '{A_NONE,  32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1, 32'h0000_0A00, 1'b0};
    rows[19] = '{A_READ,  32'h0000_0108, 32'h0000_0000, 4'h0, 1'b0, 32'h0000_0000, 1'b0};
  endtask

  task automatic run_row(int idx, row_t r);
    logic a_done;
    logic b_done;
    int   cycles;
    a_done = (r.a_op == A_NONE);
    b_done = !r.b_read;
    cycles = 0;
    @(posedge clk);
    a_req.address    <= r.a_addr;
    a_req.read       <= (r.a_op == A_READ);
    a_req.write      <= (r.a_op == A_WRITE);
    a_req.writedata  <= r.a_data;
    a_req.byteenable <= r.a_be;
    b_req.address    <= r.b_addr;
    b_req.read       <= r.b_read;
    while (!(a_done && b_done) && cycles < TIMEOUT) begin
      @(negedge clk);
      if (cycles == 0) begin  // first cycle tells hit from miss
        if (!a_done) begin
          check_bit("a_waitrequest_o", a_wait, !r.hit);
        end
        if (!b_done) begin
          check_bit("b_waitrequest_o", b_wait, !r.hit);
        end
      end
      if (!a_done && !a_wait) begin
        a_done = 1'b1;
        if (r.a_op == A_READ) begin
          check_word("a_readdata_o", a_readdata, shadow_read(r.a_addr));
        end else begin
          shadow[r.a_addr] = merge_bytes(shadow_read(r.a_addr), r.a_data, r.a_be);
        end
      end
      if (!b_done && !b_wait) begin
        b_done = 1'b1;
        check_word("b_readdata_o", b_readdata, shadow_read(r.b_addr));
      end
      @(posedge clk);
      if (a_done) begin
        a_req.read  <= 1'b0;
        a_req.write <= 1'b0;
      end
      if (b_done) begin
        b_req.read <= 1'b0;
      end
      cycles++;
    end
    if (!(a_done && b_done)) begin
      timeouts++;
      $display("row %0d: cache request still stalled after %0d cycles", idx, TIMEOUT);
    end
  endtask

  initial begin
    data_errs = 0;
    ctrl_errs = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    a_req     = '0;
    b_req     = '0;
    load_rows();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("mem_req_o.read", mem_req.read, 1'b0);
    check_bit("mem_req_o.write", mem_req.write, 1'b0);
    check_bit("a_waitrequest_o", a_wait, 1'b0);
    check_bit("b_waitrequest_o", b_wait, 1'b0);
    for (int i = 0; i < NUM_ROWS && timeouts == 0; i++) begin
      run_row(i, rows[i]);
    end
    $display("errors: data %0d, control %0d, timeouts %0d", data_errs, ctrl_errs, timeouts);
    if (data_errs + ctrl_errs + timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verification/burst_mem_model.sv
// burst memory that answers the cache testbench's master bursts with random waitrequest stalls
`timescale 1ns/1ps
module burst_mem_model import cache_pkg::*, bus_pkg::*; #(
  parameter int LINE_WORDS = 16
) (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t req_i,
  output word_t    readdata_o,
  output logic     waitrequest_o,
  output logic     readdatavalid_o
);

  localparam word_t FILL_MASK = 32'h5A5A_0000;

  word_t  mem [addr_t];  // sparse map where untouched words follow the fill rule
  integer seed;
  int     beats_left;
  addr_t  rd_addr;

  initial seed = 74;

  function automatic word_t fetch(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ FILL_MASK;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waitrequest_o   <= 1'b0;
      readdatavalid_o <= 1'b0;
      readdata_o      <= '0;
      beats_left      <= 0;
      rd_addr         <= '0;
    end else begin
      waitrequest_o   <= (($random(seed) & 3) == 0);  // about one stall in four
      readdatavalid_o <= 1'b0;
      if (req_i.write && !waitrequest_o) begin
        mem[req_i.address] = req_i.writedata;  // one beat per accepted cycle
      end
      if (req_i.read && !waitrequest_o && beats_left == 0) begin
        rd_addr    <= req_i.address;
        beats_left <= LINE_WORDS;
      end
      if (beats_left > 0) begin
        readdatavalid_o <= 1'b1;
        readdata_o      <= fetch(rd_addr);
        rd_addr         <= rd_addr + addr_t'(BYTES_PER_WORD);
        beats_left      <= beats_left - 1;
      end
    end
  end

endmodule

// File: source/dual_port_cache.sv
// top level of the two-port direct-mapped write-back cache, placed between two clients and memory
`timescale 1ns/1ps
module dual_port_cache import cache_pkg::*, bus_pkg::*; #(
  parameter int LINE_WORDS = 16,
  parameter int INDEX_BITS = 3
) (
  input  logic     clk,
  input  logic     rst_n,
  input  cpu_req_t a_req_i,
  output word_t    a_readdata_o,
  output logic     a_waitrequest_o,
  input  rd_req_t  b_req_i,
  output word_t    b_readdata_o,
  output logic     b_waitrequest_o,
  output mem_req_t mem_req_o,
  input  word_t    mem_readdata_i,
  input  logic     mem_waitrequest_i,
  input  logic     mem_readdatavalid_i
);

  localparam int NUM_LINES = 2 ** INDEX_BITS;
  localparam int OFF_BITS  = $clog2(LINE_WORDS);
  localparam int BYTE_BITS = $clog2(BYTES_PER_WORD);
  localparam int LINE_LSB  = OFF_BITS + BYTE_BITS;
  localparam int TAG_BITS  = ADDR_W - INDEX_BITS - LINE_LSB;

  typedef logic [INDEX_BITS-1:0] idx_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  word_t rd1_data [NUM_LINES];
  word_t rd2_data [NUM_LINES];
  tag_t  line_tag [NUM_LINES];
  logic [NUM_LINES-1:0] rd1_hit;
  logic [NUM_LINES-1:0] rd2_hit;
  logic [NUM_LINES-1:0] line_dirty;
  logic [NUM_LINES-1:0] line_valid;

  idx_t     a_idx;
  idx_t     b_idx;
  idx_t     wb_idx;
  idx_t     miss_idx;
  logic     a_access;
  logic     a_blocked;
  logic     miss_a;
  logic     miss_b;
  logic     miss_b_go;
  logic     wr_hit_a;
  logic     ctrl_busy;
  logic     ctrl_wr_en;
  line_wr_t ctrl_wr;
  line_wr_t direct_wr;

  assign a_idx  = a_req_i.address[LINE_LSB +: INDEX_BITS];
  assign b_idx  = b_req_i.address[LINE_LSB +: INDEX_BITS];
  assign wb_idx = mem_req_o.address[LINE_LSB +: INDEX_BITS];

  assign a_access  = a_req_i.read || a_req_i.write;
  assign miss_a    = a_access && !rd1_hit[a_idx];
  assign miss_b    = b_req_i.read && !rd2_hit[b_idx];
  assign a_blocked = a_access && ctrl_busy && (a_idx == miss_idx);  // line owned by refill
  assign miss_b_go = miss_b && !(a_req_i.write && a_idx == b_idx);  // let A's write land first
  assign wr_hit_a  = a_req_i.write && rd1_hit[a_idx] && !a_blocked;

  assign a_waitrequest_o = miss_a || a_blocked;
  assign b_waitrequest_o = miss_b;
  assign a_readdata_o    = rd1_data[a_idx];
  assign b_readdata_o    = rd2_data[b_idx];

  always_comb begin
    direct_wr.offset  = WR_OFF_W'(a_req_i.address[BYTE_BITS +: OFF_BITS]);
    direct_wr.tag     = ADDR_W'(a_req_i.address[ADDR_W-1 -: TAG_BITS]);
    direct_wr.valid   = 1'b1;
    direct_wr.dirty   = 1'b1;
    direct_wr.data    = a_req_i.writedata;
    direct_wr.byte_en = a_req_i.byteenable;
  end

  for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
    logic     own;
    addr_t    rd1_addr;
    line_wr_t wr;
    logic     wr_en;

    assign own      = ctrl_busy && (miss_idx == idx_t'(i));
    // victim words leave through read port 1 during write-back
    assign rd1_addr = (mem_req_o.write && wb_idx == idx_t'(i)) ? mem_req_o.address
                                                              : a_req_i.address;
    assign wr       = own ? ctrl_wr : direct_wr;
    assign wr_en    = own ? ctrl_wr_en : (wr_hit_a && a_idx == idx_t'(i));

    cache_line #(
      .LINE_WORDS (LINE_WORDS),
      .INDEX_BITS (INDEX_BITS)
    ) u_line (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd1_addr_i (rd1_addr),
      .rd2_addr_i (b_req_i.address),
      .wr_en_i    (wr_en),
      .wr_i       (wr),
      .rd1_data_o (rd1_data[i]),
      .rd2_data_o (rd2_data[i]),
      .rd1_hit_o  (rd1_hit[i]),
      .rd2_hit_o  (rd2_hit[i]),
      .dirty_o    (line_dirty[i]),
      .valid_o    (line_valid[i]),
      .tag_o      (line_tag[i])
    );
  end

  line_refill_ctrl #(
    .LINE_WORDS (LINE_WORDS),
    .INDEX_BITS (INDEX_BITS)
  ) u_refill_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .miss_a_i            (miss_a),
    .miss_b_i            (miss_b_go),
    .addr_a_i            (a_req_i.address),
    .addr_b_i            (b_req_i.address),
    .victim_dirty_i      (line_dirty[miss_idx] && line_valid[miss_idx]),
    .victim_tag_i        (line_tag[miss_idx]),
    .victim_data_i       (rd1_data[miss_idx]),
    .busy_o              (ctrl_busy),
    .miss_idx_o          (miss_idx),
    .line_wr_o           (ctrl_wr),
    .line_wr_en_o        (ctrl_wr_en),
    .mem_req_o           (mem_req_o),
    .mem_readdata_i      (mem_readdata_i),
    .mem_waitrequest_i   (mem_waitrequest_i),
    .mem_readdatavalid_i (mem_readdatavalid_i)
  );

endmodule

// File: source/line_refill_ctrl.sv
// miss FSM that the cache top instantiates to write back a dirty victim and refill the line
`timescale 1ns/1ps
module line_refill_ctrl import cache_pkg::*, bus_pkg::*; #(
  parameter int  LINE_WORDS = 16,
  parameter int  INDEX_BITS = 3,
  localparam int OFF_BITS   = $clog2(LINE_WORDS),
  localparam int BYTE_BITS  = $clog2(BYTES_PER_WORD),
  localparam int LINE_LSB   = OFF_BITS + BYTE_BITS,
  localparam int TAG_BITS   = ADDR_W - INDEX_BITS - LINE_LSB
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miss_a_i,
  input  logic                  miss_b_i,
  input  addr_t                 addr_a_i,
  input  addr_t                 addr_b_i,
  input  logic                  victim_dirty_i,
  input  logic [TAG_BITS-1:0]   victim_tag_i,
  input  word_t                 victim_data_i,
  output logic                  busy_o,
  output logic [INDEX_BITS-1:0] miss_idx_o,
  output line_wr_t              line_wr_o,
  output logic                  line_wr_en_o,
  output mem_req_t              mem_req_o,
  input  word_t                 mem_readdata_i,
  input  logic                  mem_waitrequest_i,
  input  logic                  mem_readdatavalid_i
);

  typedef logic [OFF_BITS-1:0] off_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  localparam off_t LAST_WORD = off_t'(LINE_WORDS - 1);

  ctrl_state_e state_q;
  off_t        cnt_q;
  logic        rd_q;
  logic        wr_q;
  addr_t       miss_addr_q;
  addr_t       base_q;

  addr_t miss_addr;
  tag_t  miss_tag;
  addr_t victim_base;
  addr_t refill_base;
  logic  start;
  logic  wb_last;
  logic  rf_last;

  // port A first and held once the FSM leaves IDLE
  assign miss_addr   = (state_q != IDLE) ? miss_addr_q : (miss_a_i ? addr_a_i : addr_b_i);
  assign miss_tag    = miss_addr[ADDR_W-1 -: TAG_BITS];
  assign miss_idx_o  = miss_addr[LINE_LSB +: INDEX_BITS];
  assign victim_base = {victim_tag_i, miss_idx_o, {LINE_LSB{1'b0}}};
  assign refill_base = {miss_tag, miss_idx_o, {LINE_LSB{1'b0}}};

  assign start   = (state_q == IDLE) && (miss_a_i || miss_b_i);
  assign wb_last = (state_q == WRITEBACK) && !mem_waitrequest_i && (cnt_q == LAST_WORD);
  assign rf_last = (state_q == REFILL) && mem_readdatavalid_i && (cnt_q == LAST_WORD);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (start) begin
            if (victim_dirty_i) begin
              state_q <= WRITEBACK;
              wr_q    <= 1'b1;
            end else begin
              state_q <= REFILL;
              rd_q    <= 1'b1;
            end
          end
        end
        WRITEBACK: begin
          if (!mem_waitrequest_i) begin
            cnt_q <= cnt_q + 1'b1;  // wraps to zero after the last beat
          end
          if (wb_last) begin
            wr_q    <= 1'b0;
            rd_q    <= 1'b1;
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (rd_q && !mem_waitrequest_i) begin
            rd_q <= 1'b0;  // one command per burst
          end
          if (mem_readdatavalid_i) begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (rf_last) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      miss_addr_q <= miss_addr;
      base_q      <= victim_dirty_i ? victim_base : refill_base;
    end else if (wb_last) begin
      base_q <= refill_base;
    end
  end

  assign busy_o       = (state_q != IDLE);
  assign line_wr_en_o = (state_q == REFILL) && mem_readdatavalid_i;

  always_comb begin
    // address steps with the beat so the top can look up the victim word
    mem_req_o.address   = base_q | addr_t'({cnt_q, {BYTE_BITS{1'b0}}});
    mem_req_o.read      = rd_q;
    mem_req_o.write     = wr_q;
    mem_req_o.writedata = victim_data_i;
  end

  always_comb begin
    line_wr_o.offset  = WR_OFF_W'(cnt_q);
    line_wr_o.tag     = ADDR_W'(miss_tag);
    line_wr_o.valid   = (cnt_q == LAST_WORD);
    line_wr_o.dirty   = 1'b0;
    line_wr_o.data    = mem_readdata_i;
    line_wr_o.byte_en = '1;
  end

endmodule

// File: source/cache_line.sv
// one direct-mapped cache line with two combinational read ports and a byte-enabled write port
`timescale 1ns/1ps
module cache_line import cache_pkg::*, bus_pkg::*; #(
  parameter int  LINE_WORDS = 16,
  parameter int  INDEX_BITS = 3,
  localparam int OFF_BITS   = $clog2(LINE_WORDS),
  localparam int BYTE_BITS  = $clog2(BYTES_PER_WORD),
  localparam int TAG_BITS   = ADDR_W - INDEX_BITS - OFF_BITS - BYTE_BITS
) (
  input  logic                clk,
  input  logic                rst_n,
  input  addr_t               rd1_addr_i,
  input  addr_t               rd2_addr_i,
  input  logic                wr_en_i,
  input  line_wr_t            wr_i,
  output word_t               rd1_data_o,
  output word_t               rd2_data_o,
  output logic                rd1_hit_o,
  output logic                rd2_hit_o,
  output logic                dirty_o,
  output logic                valid_o,
  output logic [TAG_BITS-1:0] tag_o
);

  typedef logic [OFF_BITS-1:0] off_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  word_t words_q [LINE_WORDS];
  tag_t  tag_q;
  logic  valid_q;
  logic  dirty_q;

  off_t rd1_off;
  off_t rd2_off;
  off_t wr_off;

  assign rd1_off = rd1_addr_i[BYTE_BITS +: OFF_BITS];
  assign rd2_off = rd2_addr_i[BYTE_BITS +: OFF_BITS];
  assign wr_off  = wr_i.offset[OFF_BITS-1:0];

  // index bits are matched by the line select outside
  assign rd1_hit_o  = valid_q && (tag_q == rd1_addr_i[ADDR_W-1 -: TAG_BITS]);
  assign rd2_hit_o  = valid_q && (tag_q == rd2_addr_i[ADDR_W-1 -: TAG_BITS]);
  assign rd1_data_o = words_q[rd1_off];
  assign rd2_data_o = words_q[rd2_off];

  assign dirty_o = dirty_q;
  assign valid_o = valid_q;
  assign tag_o   = tag_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (wr_i.byte_en[b]) begin
          words_q[wr_off][8*b +: 8] <= wr_i.data[8*b +: 8];  // byte merge
        end
      end
      tag_q <= wr_i.tag[TAG_BITS-1:0];
    end
  end

  // refill clears valid until its last word lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= wr_i.valid;
      dirty_q <= wr_i.dirty;
    end
  end

endmodule

// File: source/bus_pkg.sv
// request structs that the cache RTL and testbench import for client ports, memory master and line writes
package bus_pkg;

  import cache_pkg::*;

  localparam int WR_OFF_W = 8;  // widest word index a line write can carry

  // port A read or write with byte enables
  typedef struct packed {
    addr_t    address;
    logic     read;
    logic     write;
    word_t    writedata;
    byte_en_t byteenable;
  } cpu_req_t;

  // read-only port B
  typedef struct packed {
    addr_t address;
    logic  read;
  } rd_req_t;

  // burst master request with burst length fixed by LINE_WORDS
  typedef struct packed {
    addr_t address;
    logic  read;
    logic  write;
    word_t writedata;
  } mem_req_t;

  typedef struct packed {
    logic [WR_OFF_W-1:0] offset;   // word index inside the line
    logic [ADDR_W-1:0]   tag;      // upper bits unused
    logic                valid;
    logic                dirty;
    word_t               data;
    byte_en_t            byte_en;
  } line_wr_t;

endpackage

// File: source/cache_pkg.sv
// word, address and byte-enable types plus refill FSM states that every cache RTL file imports
package cache_pkg;

  localparam int ADDR_W         = 32;           // byte address
  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;   // byte offset step per burst beat

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [WORD_W-1:0]         word_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

  // any state but IDLE means the controller owns the miss line
  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    REFILL
  } ctrl_state_e;

endpackage
